// ==== Makefile ====
# Verilator build and run of the fp coprocessor testbench

TOOL   := verilator
TOP    := tb_fpu_ss
FLIST  := flist.f
FLAGS  := --binary --timing -j 0 --top-module $(TOP)
OBJDIR := obj_dir
PASS   := ALL TESTS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with $(TOOL) and run $(TOP)"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

test:
	$(TOOL) $(FLAGS) -f $(FLIST)
	@out="$$(./$(OBJDIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf $(OBJDIR)

// ==== flist.f ====
+incdir+verilog
verilog/fpu_ss_xif_pkg.sv
verilog/fpu_ss_instr_pkg.sv
verilog/fpu_ss_fpr_if.sv
verilog/fpu_ss_stream_fifo.sv
verilog/fpu_ss_decoder.sv
verilog/fpu_ss_execute.sv
verilog/fpu_ss_regfile.sv
verilog/fpu_ss.sv
sim/tb_fpu_ss.sv

// ==== sim/tb_fpu_ss.sv ====
// testbench for the fp coprocessor
// table of offloaded instructions with expected accept, writeback and result
// random result back-pressure, in-order result checking and a watchdog
`timescale 1ns/10ps

module tb_fpu_ss;

  // OP-FP encodings of the F extension
  localparam logic [6:0] OPC_FP   = 7'b1010011;
  localparam logic [6:0] F7_SGNJ  = 7'b0010000;
  localparam logic [6:0] F7_MVXW  = 7'b1110000;
  localparam logic [6:0] F7_MVWX  = 7'b1111000;

  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] rs1;
    logic        acc;
    logic        has_res;
    logic [31:0] res;
  } row_t;

  typedef struct packed {
    logic [31:0] data;
    logic [4:0]  rd;
    logic [3:0]  id;
  } exp_t;

  logic        clk_i = 1'b0;
  logic        rst_ni;
  logic        x_issue_valid_i;
  logic        x_issue_ready_o;
  logic [31:0] x_issue_instr_i;
  logic [31:0] x_issue_rs1_i;
  logic [3:0]  x_issue_id_i;
  logic        x_issue_accept_o;
  logic        x_issue_writeback_o;
  logic        x_result_valid_o;
  logic        x_result_ready_i;
  logic [31:0] x_result_data_o;
  logic [4:0]  x_result_rd_o;
  logic [3:0]  x_result_id_o;

  row_t   rows[$];
  exp_t   exp_q[$];
  int     num_rows = 0;
  integer seed = 32'hfca5380c;
  logic   saw_stall = 1'b0;

  fpu_ss fpu_ss_inst (.*);

  always #50 clk_i = ~clk_i;

  task automatic fail_and_stop();
    $display("SOME TESTS FAILED");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("ERR %s: got %h, expected %h", name, got, exp);
      fail_and_stop();
    end
  endtask

  function automatic logic [31:0] encode_fp_op(input logic [6:0] f7, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [2:0] f3,
                                               input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, OPC_FP};
  endfunction

  task automatic add_row(input logic [31:0] instr, input logic [31:0] rs1, input logic acc,
                         input logic has_res, input logic [31:0] res);
    rows.push_back('{instr, rs1, acc, has_res, res});
  endtask

  // fmv.w.x into fr, fmv.x.w of fr into x(~fr), sign injection fd = f(fa, fb)
  task automatic write_fpr(input logic [4:0] fr, input logic [31:0] val);
    add_row(encode_fp_op(F7_MVWX, 5'd0, 5'd0, 3'b000, fr), val, 1'b1, 1'b0, 32'h0);
  endtask

  task automatic read_fpr(input logic [4:0] fr, input logic [31:0] exp);
    add_row(encode_fp_op(F7_MVXW, 5'd0, fr, 3'b000, ~fr), 32'h0, 1'b1, 1'b1, exp);
  endtask

  task automatic inject(input logic [2:0] f3, input logic [4:0] fd, input logic [4:0] fa,
                        input logic [4:0] fb);
    add_row(encode_fp_op(F7_SGNJ, fb, fa, f3, fd), 32'h0, 1'b1, 1'b0, 32'h0);
  endtask

  task automatic build_table();
    logic [31:0] v;
    logic [4:0]  r;
    // untouched registers read zero
    read_fpr(5'd5, 32'h0);
    read_fpr(5'd31, 32'h0);
    // f1 = +1.5, f2 = -pi
    write_fpr(5'd1, 32'h3fc00000);
    read_fpr(5'd1, 32'h3fc00000);
    write_fpr(5'd2, 32'hc0490fdb);
    read_fpr(5'd2, 32'hc0490fdb);
    // magnitude of the first source and sign from the rule
    inject(3'b000, 5'd3, 5'd1, 5'd2);
    read_fpr(5'd3, 32'hbfc00000);
    inject(3'b001, 5'd4, 5'd1, 5'd2);
    read_fpr(5'd4, 32'h3fc00000);
    inject(3'b010, 5'd6, 5'd2, 5'd2);
    read_fpr(5'd6, 32'h40490fdb);
    inject(3'b010, 5'd7, 5'd2, 5'd1);
    read_fpr(5'd7, 32'hc0490fdb);
    inject(3'b001, 5'd8, 5'd2, 5'd1);
    read_fpr(5'd8, 32'hc0490fdb);
    inject(3'b000, 5'd9, 5'd2, 5'd1);
    read_fpr(5'd9, 32'h40490fdb);
    // refused forms all aimed at f1
    add_row(encode_fp_op(F7_SGNJ, 5'd2, 5'd2, 3'b011, 5'd1), 32'h0, 1'b0, 1'b0, 32'h0);
    add_row(encode_fp_op(F7_MVWX, 5'd3, 5'd0, 3'b000, 5'd1), 32'hdeadbeef, 1'b0, 1'b0, 32'h0);
    // flw opcode, fadd.s and fclass.s
    add_row({F7_MVWX, 5'd0, 5'd0, 3'b000, 5'd1, 7'b0000111}, 32'h12345678, 1'b0, 1'b0, 32'h0);
    add_row(encode_fp_op(7'b0000000, 5'd2, 5'd2, 3'b000, 5'd1), 32'h0, 1'b0, 1'b0, 32'h0);
    add_row(encode_fp_op(F7_MVXW, 5'd0, 5'd1, 3'b001, 5'd1), 32'h0, 1'b0, 1'b0, 32'h0);
    read_fpr(5'd1, 32'h3fc00000);
    // long burst dense in results
    for (int k = 0; k < 16; k++) begin
      v = $random(seed);
      r = 5'(16 + k);
      write_fpr(r, v);
      read_fpr(r, v);
      inject(3'b001, r, r, r);
      read_fpr(r, {~v[31], v[30:0]});
    end
  endtask

  // main sequence and issue driver
  initial begin
    rst_ni          = 1'b0;
    x_issue_valid_i = 1'b0;
    x_issue_instr_i = 32'h0;
    x_issue_rs1_i   = 32'h0;
    x_issue_id_i    = 4'h0;
    build_table();
    num_rows = rows.size();
    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    #1;
    check_value("x_result_valid_o", 32'(x_result_valid_o), 32'h0);
    check_value("x_issue_ready_o", 32'(x_issue_ready_o), 32'h1);
    for (int i = 0; i < num_rows; i++) begin
      @(negedge clk_i);
      x_issue_valid_i = 1'b1;
      x_issue_instr_i = rows[i].instr;
      x_issue_rs1_i   = rows[i].rs1;
      x_issue_id_i    = i[3:0];
      #1;
      check_value("x_issue_accept_o", 32'(x_issue_accept_o), 32'(rows[i].acc));
      check_value("x_issue_writeback_o", 32'(x_issue_writeback_o), 32'(rows[i].has_res));
      // ready only changes on the rising edge
      while (!x_issue_ready_o) begin
        if (x_result_valid_o) saw_stall = 1'b1;
        @(negedge clk_i);
        #1;
      end
      // transfer happens on the coming rising edge
      if (rows[i].has_res) begin
        exp_q.push_back('{rows[i].res, rows[i].instr[11:7], i[3:0]});
      end
    end
    @(negedge clk_i);
    x_issue_valid_i = 1'b0;
    while (exp_q.size() != 0) @(negedge clk_i);
    // refused instructions must not leave a stray result behind
    repeat (8) @(negedge clk_i);
    #1;
    check_value("x_result_valid_o", 32'(x_result_valid_o), 32'h0);
    if (!saw_stall) begin
      $display("x_issue_ready_o never fell while a result was held");
      fail_and_stop();
    end else begin
      $display("ALL TESTS PASSED");
      $finish;
    end
  end

  // random result ready and in-order result monitor
  initial begin
    exp_t   e;
    integer rnd;
    x_result_ready_i = 1'b0;
    @(posedge rst_ni);
    forever begin
      @(negedge clk_i);
      rnd = $random(seed);
      x_result_ready_i = rnd[0];
      #1;
      // valid and ready now hold until the next rising edge
      if (x_result_valid_o && x_result_ready_i) begin
        if (exp_q.size() == 0) begin
          $display("result handshake with no result outstanding");
          fail_and_stop();
        end else begin
          e = exp_q.pop_front();
          check_value("x_result_data_o", x_result_data_o, e.data);
          check_value("x_result_rd_o", 32'(x_result_rd_o), 32'(e.rd));
          check_value("x_result_id_o", 32'(x_result_id_o), 32'(e.id));
        end
      end
    end
  end

  // watchdog allows 40 cycles per table row
  initial begin
    wait (num_rows != 0);
    repeat (num_rows * 40) @(posedge clk_i);
    $display("timeout, the run did not finish in time");
    fail_and_stop();
  end

endmodule

// ==== verilog/fpu_ss.sv ====
// fp coprocessor top level behind the core offload port
// decoder, input buffer, execute stage and fp register file
`timescale 1ns/10ps
`include "fpu_ss_defs.svh"

module fpu_ss (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // issue handshake
  input  logic                  x_issue_valid_i,
  output logic                  x_issue_ready_o,
  input  logic [31:0]           x_issue_instr_i,
  input  fpu_ss_xif_pkg::data_t x_issue_rs1_i,
  input  fpu_ss_xif_pkg::id_t   x_issue_id_i,
  output logic                  x_issue_accept_o,
  output logic                  x_issue_writeback_o,
  // result handshake
  output logic                  x_result_valid_o,
  input  logic                  x_result_ready_i,
  output fpu_ss_xif_pkg::data_t x_result_data_o,
  output logic [4:0]            x_result_rd_o,
  output fpu_ss_xif_pkg::id_t   x_result_id_o
);
  import fpu_ss_instr_pkg::*;
  import fpu_ss_xif_pkg::*;

  decoded_t dec_entry;
  decoded_t buf_entry;
  logic     dec_accept;
  logic     buf_push_valid;
  logic     buf_pop_valid;
  logic     buf_pop_ready;
  result_t  res;

  fpu_ss_fpr_if fpr_bus ();

  fpu_ss_decoder decoder_inst (
    .instr_i     (x_issue_instr_i),
    .rs1_i       (x_issue_rs1_i),
    .id_i        (x_issue_id_i),
    .accept_o    (dec_accept),
    .writeback_o (x_issue_writeback_o),
    .entry_o     (dec_entry)
  );

  // refused instructions are consumed without entering the buffer
  assign x_issue_accept_o = dec_accept;
  assign buf_push_valid   = x_issue_valid_i && dec_accept;

  fpu_ss_stream_fifo #(
    .T     (decoded_t),
    .DEPTH (`FPU_SS_IN_DEPTH)
  ) in_buf_inst (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .push_valid_i (buf_push_valid),
    .push_ready_o (x_issue_ready_o),
    .push_data_i  (dec_entry),
    .pop_valid_o  (buf_pop_valid),
    .pop_ready_i  (buf_pop_ready),
    .pop_data_o   (buf_entry)
  );

  fpu_ss_execute execute_inst (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .in_valid_i  (buf_pop_valid),
    .in_ready_o  (buf_pop_ready),
    .in_entry_i  (buf_entry),
    .fpr         (fpr_bus),
    .res_valid_o (x_result_valid_o),
    .res_ready_i (x_result_ready_i),
    .res_o       (res)
  );

  fpu_ss_regfile regfile_inst (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .fpr    (fpr_bus)
  );

  // result fields onto plain ports
  assign x_result_data_o = res.data;
  assign x_result_rd_o   = res.rd;
  assign x_result_id_o   = res.id;

endmodule

// ==== verilog/fpu_ss_decoder.sv ====
// offload decoder for the fmv and sign injection subset
// produces accept, writeback and the entry pushed into the input buffer
`timescale 1ns/10ps
`include "fpu_ss_defs.svh"

module fpu_ss_decoder (
  input  logic [31:0]                instr_i,
  input  logic [`FPU_SS_DATA_W-1:0]  rs1_i,
  input  fpu_ss_xif_pkg::id_t        id_i,
  output logic                       accept_o,
  output logic                       writeback_o,
  output fpu_ss_instr_pkg::decoded_t entry_o
);
  import fpu_ss_instr_pkg::*;

  logic [6:0] opcode;
  logic [6:0] funct7;
  logic [2:0] funct3;
  logic [4:0] rs2;
  logic       legal;
  fpu_op_e    op;

  // standard R-type field positions
  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign rs2    = instr_i[24:20];
  assign funct7 = instr_i[31:25];

  always_comb begin
    legal = 1'b0;
    op    = SGNJ;
    if (opcode == `FPU_SS_OPC_OP_FP) begin
      unique case (funct7)
        `FPU_SS_F7_SGNJ: begin
          // funct3 picks the sign rule
          legal = 1'b1;
          unique case (funct3)
            `FPU_SS_RM_SGNJ:  op = SGNJ;
            `FPU_SS_RM_SGNJN: op = SGNJN;
            `FPU_SS_RM_SGNJX: op = SGNJX;
            default:          legal = 1'b0;
          endcase
        end
        // fmv forms share funct3 zero and an unused rs2 field
        `FPU_SS_F7_MV_X_W: begin
          op    = MV_X_W;
          legal = (funct3 == 3'b000) && (rs2 == 5'd0);
        end
        `FPU_SS_F7_MV_W_X: begin
          op    = MV_W_X;
          legal = (funct3 == 3'b000) && (rs2 == 5'd0);
        end
        default: legal = 1'b0;
      endcase
    end
  end

  assign accept_o    = legal;
  // only fmv.x.w returns a value to the core
  assign writeback_o = legal && (op == MV_X_W);

  assign entry_o.op      = op;
  assign entry_o.rd      = instr_i[11:7];
  assign entry_o.rs1     = instr_i[19:15];
  assign entry_o.rs2     = rs2;
  assign entry_o.operand = rs1_i;
  assign entry_o.id      = id_i;

endmodule

// ==== verilog/fpu_ss_defs.svh ====
// constants shared by the fp coprocessor
// register file size, input buffer depth, word width and OP-FP encodings
`ifndef FPU_SS_DEFS_SVH
`define FPU_SS_DEFS_SVH

// sizes
`define FPU_SS_NUM_FPR  32
`define FPU_SS_IN_DEPTH 2
`define FPU_SS_DATA_W   32

// major opcode shared by all supported instructions
`define FPU_SS_OPC_OP_FP 7'b1010011

// funct7 of sign injection, fmv.x.w and fmv.w.x
`define FPU_SS_F7_SGNJ   7'b0010000
`define FPU_SS_F7_MV_X_W 7'b1110000
`define FPU_SS_F7_MV_W_X 7'b1111000

// funct3 inside the sign injection group
`define FPU_SS_RM_SGNJ  3'b000
`define FPU_SS_RM_SGNJN 3'b001
`define FPU_SS_RM_SGNJX 3'b010

`endif

// ==== verilog/fpu_ss_execute.sv ====
// in-order single cycle execute stage
// reads fp operands, computes sign injection or moves, writes fpr or result
// holds the result register toward the core
`timescale 1ns/10ps
`include "fpu_ss_defs.svh"

module fpu_ss_execute (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  input  fpu_ss_instr_pkg::decoded_t in_entry_i,
  fpu_ss_fpr_if.exec                 fpr,
  output logic                       res_valid_o,
  input  logic                       res_ready_i,
  output fpu_ss_xif_pkg::result_t    res_o
);
  import fpu_ss_instr_pkg::*;
  import fpu_ss_xif_pkg::*;

  localparam int unsigned SIGN = `FPU_SS_DATA_W - 1;

  logic                      is_mv_x_w;
  logic                      res_free;
  logic                      fire;
  logic [`FPU_SS_DATA_W-1:0] op_a;
  logic [`FPU_SS_DATA_W-1:0] op_b;
  logic [`FPU_SS_DATA_W-1:0] wdata;
  logic                      res_valid_q;
  result_t                   res_q;

  // result slot is usable when empty or drained this cycle
  assign is_mv_x_w = (in_entry_i.op == MV_X_W);
  assign res_free  = !res_valid_q || res_ready_i;
  // stall only a move to the core while its slot is taken
  assign in_ready_o = !is_mv_x_w || res_free;
  assign fire       = in_valid_i && in_ready_o;

  // operand fetch
  assign fpr.raddr_a = in_entry_i.rs1;
  assign fpr.raddr_b = in_entry_i.rs2;
  assign op_a        = fpr.rdata_a;
  assign op_b        = fpr.rdata_b;

  always_comb begin
    unique case (in_entry_i.op)
      MV_W_X:  wdata = in_entry_i.operand;
      SGNJ:    wdata = {op_b[SIGN], op_a[SIGN-1:0]};
      SGNJN:   wdata = {~op_b[SIGN], op_a[SIGN-1:0]};
      // sign is the xor of both signs
      SGNJX:   wdata = {op_a[SIGN] ^ op_b[SIGN], op_a[SIGN-1:0]};
      default: wdata = op_a;
    endcase
  end

  // write lands on the popping edge, the next entry already sees it
  assign fpr.waddr = in_entry_i.rd;
  assign fpr.wdata = wdata;
  assign fpr.we    = fire && !is_mv_x_w;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      res_valid_q <= 1'b0;
    end else if (fire && is_mv_x_w) begin
      res_valid_q <= 1'b1;
    end else if (res_ready_i) begin
      res_valid_q <= 1'b0;
    end
  end

  // payload held until the handshake completes
  always_ff @(posedge clk_i) begin
    if (fire && is_mv_x_w) begin
      res_q.data <= op_a;
      res_q.rd   <= in_entry_i.rd;
      res_q.id   <= in_entry_i.id;
    end
  end

  assign res_valid_o = res_valid_q;
  assign res_o       = res_q;

endmodule

// ==== verilog/fpu_ss_fpr_if.sv ====
// fp register file access bundle
// two read ports and one write port, with execute and register file views
`timescale 1ns/10ps
`include "fpu_ss_defs.svh"

interface fpu_ss_fpr_if;
  import fpu_ss_instr_pkg::*;

  // read side, data returns in the same cycle
  reg_addr_t                 raddr_a;
  reg_addr_t                 raddr_b;
  logic [`FPU_SS_DATA_W-1:0] rdata_a;
  logic [`FPU_SS_DATA_W-1:0] rdata_b;

  // write side, lands on the next rising edge
  reg_addr_t                 waddr;
  logic [`FPU_SS_DATA_W-1:0] wdata;
  logic                      we;

  modport exec (output raddr_a, raddr_b, waddr, wdata, we, input rdata_a, rdata_b);
  modport rf (input raddr_a, raddr_b, waddr, wdata, we, output rdata_a, rdata_b);

endinterface

// ==== verilog/fpu_ss_instr_pkg.sv ====
// decoded instruction types of the fp coprocessor
// operation enum, register address and the buffered instruction entry
`include "fpu_ss_defs.svh"

package fpu_ss_instr_pkg;

  // supported operations, bit-exact subset of F only
  typedef enum logic [2:0] {
    MV_W_X = 3'd0,
    MV_X_W = 3'd1,
    SGNJ   = 3'd2,
    SGNJN  = 3'd3,
    SGNJX  = 3'd4
  } fpu_op_e;

  // fp register index
  typedef logic [$clog2(`FPU_SS_NUM_FPR)-1:0] reg_addr_t;

  // entry stored in the input buffer
  typedef struct packed {
    fpu_op_e                 op;
    reg_addr_t               rd;
    reg_addr_t               rs1;
    reg_addr_t               rs2;
    fpu_ss_xif_pkg::data_t   operand;
    fpu_ss_xif_pkg::id_t     id;
  } decoded_t;

endpackage

// ==== verilog/fpu_ss_regfile.sv ====
// floating-point register file
// two combinational read ports, one write port, cleared on reset
`timescale 1ns/10ps
`include "fpu_ss_defs.svh"

module fpu_ss_regfile (
  input  logic     clk_i,
  input  logic     rst_ni,
  fpu_ss_fpr_if.rf fpr
);

  logic [`FPU_SS_DATA_W-1:0] regs_q [`FPU_SS_NUM_FPR];

  // registers start at zero so untouched reads are defined
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < `FPU_SS_NUM_FPR; i++) begin
        regs_q[i] <= '0;
      end
    end else if (fpr.we) begin
      regs_q[fpr.waddr] <= fpr.wdata;
    end
  end

  // read ports
  assign fpr.rdata_a = regs_q[fpr.raddr_a];
  assign fpr.rdata_b = regs_q[fpr.raddr_b];

endmodule

// ==== verilog/fpu_ss_stream_fifo.sv ====
// valid/ready circular buffer with a type-parameterized payload
// output comes from storage only, so a pushed entry is seen one cycle later
`timescale 1ns/10ps

module fpu_ss_stream_fifo #(
  parameter type         T     = logic,
  parameter int unsigned DEPTH = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic push_valid_i,
  output logic push_ready_o,
  input  T     push_data_i,
  output logic pop_valid_o,
  input  logic pop_ready_i,
  output T     pop_data_o
);

  localparam int unsigned PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(DEPTH + 1);

  T                 mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0] cnt_q;
  logic             push;
  logic             pop;

  // full and empty straight from the occupancy count
  assign push_ready_o = (cnt_q != CNT_W'(DEPTH));
  assign pop_valid_o  = (cnt_q != '0);
  assign push         = push_valid_i && push_ready_o;
  assign pop          = pop_valid_o && pop_ready_i;
  assign pop_data_o   = mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      // pointers wrap at DEPTH, which need not be a power of two
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      // simultaneous push and pop leaves the count unchanged
      cnt_q <= cnt_q + CNT_W'(push) - CNT_W'(pop);
    end
  end

  // payload storage
  always_ff @(posedge clk_i) begin
    if (push) begin
      mem_q[wr_ptr_q] <= push_data_i;
    end
  end

endmodule

// ==== verilog/fpu_ss_xif_pkg.sv ====
// offload-side types of the fp coprocessor
// instruction id, operand word and the result returned to the core
`include "fpu_ss_defs.svh"

package fpu_ss_xif_pkg;

  // id tag the core attaches to each offloaded instruction
  typedef logic [3:0] id_t;

  // integer operand and result word
  typedef logic [`FPU_SS_DATA_W-1:0] data_t;

  // result returned over the result handshake
  typedef struct packed {
    data_t                               data;
    logic [$clog2(`FPU_SS_NUM_FPR)-1:0]  rd;
    id_t                                 id;
  } result_t;

endpackage
